//--- hdl/udp_cmd_macros.svh
`ifndef UDP_CMD_MACROS_SVH
`define UDP_CMD_MACROS_SVH

// udp ports and payload framing
`define CTRL_UDP_PORT   16'h6789
`define MAGIC_WORD      16'hCBAE
`define CMD_PACKET_TYPE 8'hE1

// lengths at or below this carry no usable command
`define MIN_UDP_LEN     16'd14

// command and result buffer depth
`define CMD_BUF_AW      10

// register map
`define NUM_SETTINGS    8
`define GOOD_CNT_ADDR   15'h1FE
`define BAD_CNT_ADDR    15'h1FF
`define BAD_READ_WORD   16'h0BAD

`endif

//--- hdl/udp_cmd_pkg.sv
package udp_cmd_pkg;

    // inbound ip/udp header from the stack
    typedef struct packed {
        logic [12:0] frag_offset;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic        err;
    } udp_rx_hdr_t;

    typedef struct packed {
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } udp_route_t;

    typedef struct packed {
        udp_route_t  route;
        logic [15:0] udp_len;
    } udp_tx_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } axis_byte_t;

    // command view with the write flag on top
    typedef struct packed {
        logic        wr;
        logic [14:0] addr;
    } cmd_view_t;

    typedef union packed {
        logic [15:0] raw;
        cmd_view_t   cmd;
    } cmd_word_u;

    typedef struct packed {
        logic        valid;
        logic        wr;
        logic [14:0] addr;
        logic [15:0] data;
    } reg_req_t;

    typedef struct packed {
        logic [15:0] good;
        logic [15:0] bad;
    } pkt_counts_t;

endpackage

//--- hdl/cmd_seq_ctrl.sv
module cmd_seq_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,
    input  logic                     rx_done,
    input  logic                     rx_ok,
    input  logic                     exec_busy,
    input  logic                     tx_done,
    output logic                     exec_start,
    output logic                     tx_start,
    output udp_cmd_pkg::pkt_counts_t counts
);

    typedef enum logic [1:0] {
        IDLE,
        RECV,
        EXEC,
        REPLY
    } state_t;

    state_t state;
    logic   busy_q;
    logic   rx_bad;
    logic   take_hdr;
    state_t after_pkt;

    assign rx_bad = rx_done && !rx_ok;

    // a waiting header may be taken as soon as the previous packet ends
    assign take_hdr = in_hdr_valid && (state == IDLE ||
                                       (state == RECV && rx_bad) ||
                                       (state == REPLY && tx_done));

    assign after_pkt = take_hdr ? RECV : IDLE;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= IDLE;
            in_hdr_ready <= 1'b0;
            exec_start   <= 1'b0;
            tx_start     <= 1'b0;
            busy_q       <= 1'b0;
            counts       <= '0;
        end
        else
        begin
            in_hdr_ready <= take_hdr;
            exec_start   <= 1'b0;
            tx_start     <= 1'b0;
            busy_q       <= exec_busy;
            case (state)
                IDLE:
                    state <= after_pkt;
                RECV:
                    if (rx_done && rx_ok)
                    begin
                        exec_start <= 1'b1;
                        state      <= EXEC;
                    end
                    else if (rx_bad)
                        state <= after_pkt;
                EXEC:
                    // falling edge of busy ends execution
                    if (busy_q && !exec_busy)
                    begin
                        tx_start <= 1'b1;
                        state    <= REPLY;
                    end
                REPLY:
                    if (tx_done)
                        state <= after_pkt;
                default:
                    state <= IDLE;
            endcase
            if (tx_done)
                counts.good <= counts.good + 16'd1;
            if (rx_bad)
                counts.bad <= counts.bad + 16'd1;
        end
    end

endmodule

//--- hdl/udp_cmd_rx.sv
`include "udp_cmd_macros.svh"

module udp_cmd_rx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [31:0]                local_ip,
    input  udp_cmd_pkg::udp_rx_hdr_t   in_hdr,
    input  logic                       hdr_take,
    input  udp_cmd_pkg::axis_byte_t    in_payload,
    input  logic                       in_payload_valid,
    output logic                       in_payload_ready,
    output logic                       rx_done,
    output logic                       rx_ok,
    output udp_cmd_pkg::udp_route_t    route,
    output logic [15:0]                seq,
    output logic [`CMD_BUF_AW-1:0]     cmd_count,
    input  logic [`CMD_BUF_AW-1:0]     buf_addr,
    output udp_cmd_pkg::cmd_word_u     buf_word
);

    localparam int AW = `CMD_BUF_AW;

    logic [15:0]   buf_mem [2**AW];
    logic          beat;
    logic          lo_phase;
    logic [7:0]    hi_byte;
    logic [15:0]   cur_word;
    logic [AW-1:0] widx;
    logic [15:0]   len_q;
    logic          hdr_ok;
    logic          hdr_good;
    logic          frame_ok;

    assign beat     = in_payload_valid && in_payload_ready;
    assign cur_word = {hi_byte, in_payload.data};
    // L is odd, so the pair count is L >> 1
    assign cmd_count = len_q[AW:1];

    assign hdr_good = (in_hdr.dst_ip == local_ip || in_hdr.dst_ip == '1) &&
                      in_hdr.dst_port == `CTRL_UDP_PORT && !in_hdr.err &&
                      in_hdr.frag_offset == '0 && in_hdr.udp_len > `MIN_UDP_LEN;

    // judged on the last beat with magic at word L after the length word
    assign frame_ok = lo_phase && cur_word == `MAGIC_WORD &&
                      16'(widx) == len_q + 16'd1 && len_q[0] && len_q > 16'd1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            in_payload_ready <= 1'b0;
            rx_done          <= 1'b0;
            rx_ok            <= 1'b0;
            lo_phase         <= 1'b0;
            widx             <= '0;
            len_q            <= '0;
            hdr_ok           <= 1'b0;
        end
        else
        begin
            rx_done <= beat && in_payload.last;
            if (hdr_take)
            begin
                in_payload_ready <= 1'b1;
                hdr_ok           <= hdr_good;
                lo_phase         <= 1'b0;
                widx             <= '0;
                len_q            <= '0;
            end
            else if (beat)
            begin
                lo_phase <= !lo_phase;
                if (lo_phase)
                begin
                    widx <= widx + AW'(1);
                    if (widx == AW'(1))
                        len_q <= cur_word;
                end
                if (in_payload.last)
                begin
                    in_payload_ready <= 1'b0;
                    rx_ok            <= hdr_ok && frame_ok;
                end
            end
        end
    end

    // swapped route for the reply
    always_ff @(posedge clk)
    begin
        if (hdr_take)
        begin
            route.dst_ip   <= in_hdr.src_ip;
            route.src_port <= in_hdr.dst_port;
            route.dst_port <= in_hdr.src_port;
        end
        if (beat && !lo_phase)
            hi_byte <= in_payload.data;
        if (beat && lo_phase && widx == '0)
            seq <= cur_word;
    end

    always_ff @(posedge clk)
    begin
        if (beat && lo_phase)
            buf_mem[widx] <= cur_word;
        buf_word.raw <= buf_mem[buf_addr];
    end

endmodule

//--- hdl/cmd_exec.sv
`include "udp_cmd_macros.svh"

module cmd_exec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      exec_start,
    input  logic [`CMD_BUF_AW-1:0]    cmd_count,
    input  udp_cmd_pkg::cmd_word_u    buf_word,
    output logic [`CMD_BUF_AW-1:0]    buf_addr,
    output logic                      exec_busy,
    output udp_cmd_pkg::reg_req_t     reg_req,
    input  logic [15:0]               reg_rdata,
    output logic                      res_we,
    output logic [`CMD_BUF_AW-1:0]    res_addr,
    output logic [15:0]               res_word
);

    localparam int AW = `CMD_BUF_AW;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD_CMD,
        S_RD_DAT,
        S_ISSUE
    } state_t;

    state_t                 state;
    udp_cmd_pkg::cmd_word_u cmd_q;
    logic [AW-1:0]          res_idx;

    // buffer address runs one word ahead of the read data
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= S_IDLE;
            exec_busy <= 1'b0;
            buf_addr  <= '0;
            res_idx   <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (exec_start)
                    begin
                        // first command follows the sequence and length words
                        buf_addr  <= AW'(2);
                        res_idx   <= '0;
                        exec_busy <= 1'b1;
                        state     <= S_RD_CMD;
                    end
                S_RD_CMD:
                begin
                    buf_addr <= buf_addr + AW'(1);
                    state    <= S_RD_DAT;
                end
                S_RD_DAT:
                begin
                    buf_addr <= buf_addr + AW'(1);
                    state    <= S_ISSUE;
                end
                default:
                begin
                    buf_addr <= buf_addr + AW'(1);
                    res_idx  <= res_idx + AW'(1);
                    if (res_idx == cmd_count - AW'(1))
                    begin
                        exec_busy <= 1'b0;
                        state     <= S_IDLE;
                    end
                    else
                        state <= S_RD_DAT;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_RD_DAT)
            cmd_q <= buf_word;
    end

    always_comb
    begin
        reg_req.valid = (state == S_ISSUE);
        reg_req.wr    = cmd_q.cmd.wr;
        reg_req.addr  = cmd_q.cmd.addr;
        reg_req.data  = buf_word.raw;
    end

    assign res_we   = reg_req.valid;
    assign res_addr = res_idx;
    // writes echo their data word
    assign res_word = cmd_q.cmd.wr ? buf_word.raw : reg_rdata;

endmodule

//--- hdl/cmd_reg_bank.sv
`include "udp_cmd_macros.svh"

module cmd_reg_bank (
    input  logic                            clk,
    input  logic                            rst,
    input  udp_cmd_pkg::reg_req_t           reg_req,
    input  udp_cmd_pkg::pkt_counts_t        counts,
    output logic [15:0]                     reg_rdata,
    output logic [`NUM_SETTINGS-1:0][15:0]  settings
);

    localparam int SW = $clog2(`NUM_SETTINGS);

    logic in_bank;

    assign in_bank = reg_req.addr < 15'(`NUM_SETTINGS);

    always_ff @(posedge clk)
    begin
        if (rst)
            settings <= '0;
        else if (reg_req.valid && reg_req.wr && in_bank)
            settings[reg_req.addr[SW-1:0]] <= reg_req.data;
    end

    // readback in the request cycle
    always_comb
    begin
        if (in_bank)
            reg_rdata = settings[reg_req.addr[SW-1:0]];
        else if (reg_req.addr == `GOOD_CNT_ADDR)
            reg_rdata = counts.good;
        else if (reg_req.addr == `BAD_CNT_ADDR)
            reg_rdata = counts.bad;
        else
            reg_rdata = `BAD_READ_WORD;
    end

endmodule

//--- hdl/udp_reply_tx.sv
`include "udp_cmd_macros.svh"

module udp_reply_tx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      tx_start,
    input  udp_cmd_pkg::udp_route_t   route,
    input  logic [15:0]               seq,
    input  logic [`CMD_BUF_AW-1:0]    cmd_count,
    input  logic                      res_we,
    input  logic [`CMD_BUF_AW-1:0]    res_addr,
    input  logic [15:0]               res_word,
    output udp_cmd_pkg::udp_tx_hdr_t  out_hdr,
    output logic                      out_hdr_valid,
    output udp_cmd_pkg::axis_byte_t   out_payload,
    output logic                      out_payload_valid,
    input  logic                      out_hdr_ready,
    input  logic                      out_payload_ready,
    output logic                      tx_done
);

    localparam int AW = `CMD_BUF_AW;

    logic [15:0]   res_mem [2**AW];
    logic [AW+1:0] bidx;
    logic [AW+1:0] last_idx;
    logic [AW-1:0] word_idx;
    logic [15:0]   word_sel;
    logic          pay_beat;

    always_ff @(posedge clk)
    begin
        if (res_we)
            res_mem[res_addr] <= res_word;
    end

    // udp header plus 4 preamble bytes plus 2 bytes per result
    assign out_hdr.route   = route;
    assign out_hdr.udp_len = 16'd12 + 16'({cmd_count, 1'b0});

    assign last_idx = {1'b0, cmd_count, 1'b0} + (AW+2)'(3);
    assign word_idx = bidx[AW:1] - AW'(2);
    assign word_sel = res_mem[word_idx];
    assign pay_beat = out_payload_valid && out_payload_ready;
    assign tx_done  = pay_beat && out_payload.last;

    always_comb
    begin
        case (bidx)
            (AW+2)'(0): out_payload.data = 8'h00;
            (AW+2)'(1): out_payload.data = `CMD_PACKET_TYPE;
            (AW+2)'(2): out_payload.data = seq[15:8];
            (AW+2)'(3): out_payload.data = seq[7:0];
            default:    out_payload.data = bidx[0] ? word_sel[7:0] : word_sel[15:8];
        endcase
        out_payload.last = (bidx == last_idx);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_hdr_valid     <= 1'b0;
            out_payload_valid <= 1'b0;
            bidx              <= '0;
        end
        else
        begin
            if (tx_start)
                out_hdr_valid <= 1'b1;
            if (out_hdr_valid && out_hdr_ready)
            begin
                out_hdr_valid     <= 1'b0;
                out_payload_valid <= 1'b1;
                bidx              <= '0;
            end
            // byte index only moves on acceptance
            else if (pay_beat)
            begin
                if (out_payload.last)
                    out_payload_valid <= 1'b0;
                else
                    bidx <= bidx + (AW+2)'(1);
            end
        end
    end

endmodule

//--- hdl/udp_cmd_top.sv
`include "udp_cmd_macros.svh"

module udp_cmd_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [31:0]                         local_ip,
    input  udp_cmd_pkg::udp_rx_hdr_t            in_hdr,
    input  logic                                in_hdr_valid,
    output logic                                in_hdr_ready,
    input  udp_cmd_pkg::axis_byte_t             in_payload,
    input  logic                                in_payload_valid,
    output logic                                in_payload_ready,
    output udp_cmd_pkg::udp_tx_hdr_t            out_hdr,
    output logic                                out_hdr_valid,
    input  logic                                out_hdr_ready,
    output udp_cmd_pkg::axis_byte_t             out_payload,
    output logic                                out_payload_valid,
    input  logic                                out_payload_ready,
    output logic [`NUM_SETTINGS-1:0][15:0]      settings
);

    logic                        rx_done;
    logic                        rx_ok;
    logic                        exec_start;
    logic                        exec_busy;
    logic                        tx_start;
    logic                        tx_done;
    udp_cmd_pkg::pkt_counts_t    counts;
    udp_cmd_pkg::udp_route_t     route;
    logic [15:0]                 seq;
    logic [`CMD_BUF_AW-1:0]      cmd_count;
    logic [`CMD_BUF_AW-1:0]      buf_addr;
    udp_cmd_pkg::cmd_word_u      buf_word;
    udp_cmd_pkg::reg_req_t       reg_req;
    logic [15:0]                 reg_rdata;
    logic                        res_we;
    logic [`CMD_BUF_AW-1:0]      res_addr;
    logic [15:0]                 res_word;

    cmd_seq_ctrl cmd_seq_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .in_hdr_valid (in_hdr_valid),
        .in_hdr_ready (in_hdr_ready),
        .rx_done      (rx_done),
        .rx_ok        (rx_ok),
        .exec_busy    (exec_busy),
        .tx_done      (tx_done),
        .exec_start   (exec_start),
        .tx_start     (tx_start),
        .counts       (counts)
    );

    udp_cmd_rx udp_cmd_rx_i (
        .clk              (clk),
        .rst              (rst),
        .local_ip         (local_ip),
        .in_hdr           (in_hdr),
        .hdr_take         (in_hdr_ready),
        .in_payload       (in_payload),
        .in_payload_valid (in_payload_valid),
        .in_payload_ready (in_payload_ready),
        .rx_done          (rx_done),
        .rx_ok            (rx_ok),
        .route            (route),
        .seq              (seq),
        .cmd_count        (cmd_count),
        .buf_addr         (buf_addr),
        .buf_word         (buf_word)
    );

    cmd_exec cmd_exec_i (
        .clk        (clk),
        .rst        (rst),
        .exec_start (exec_start),
        .cmd_count  (cmd_count),
        .buf_word   (buf_word),
        .buf_addr   (buf_addr),
        .exec_busy  (exec_busy),
        .reg_req    (reg_req),
        .reg_rdata  (reg_rdata),
        .res_we     (res_we),
        .res_addr   (res_addr),
        .res_word   (res_word)
    );

    cmd_reg_bank cmd_reg_bank_i (
        .clk       (clk),
        .rst       (rst),
        .reg_req   (reg_req),
        .counts    (counts),
        .reg_rdata (reg_rdata),
        .settings  (settings)
    );

    udp_reply_tx udp_reply_tx_i (
        .clk               (clk),
        .rst               (rst),
        .tx_start          (tx_start),
        .route             (route),
        .seq               (seq),
        .cmd_count         (cmd_count),
        .res_we            (res_we),
        .res_addr          (res_addr),
        .res_word          (res_word),
        .out_hdr           (out_hdr),
        .out_hdr_valid     (out_hdr_valid),
        .out_payload       (out_payload),
        .out_payload_valid (out_payload_valid),
        .out_hdr_ready     (out_hdr_ready),
        .out_payload_ready (out_payload_ready),
        .tx_done           (tx_done)
    );

endmodule

//--- test/udp_cmd_assert.sv
module udp_cmd_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_hdr_ready,
    input logic                     in_payload_ready,
    input udp_cmd_pkg::udp_tx_hdr_t out_hdr,
    input logic                     out_hdr_valid,
    input logic                     out_hdr_ready,
    input udp_cmd_pkg::axis_byte_t  out_payload,
    input logic                     out_payload_valid,
    input logic                     out_payload_ready,
    input logic                     rx_done,
    input logic                     exec_start,
    input logic                     tx_start,
    input logic                     tx_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // outputs clear one edge after reset is sampled
    reset_quiet: assert property (@(posedge clk)
        rst |=> !in_hdr_ready && !in_payload_ready && !out_hdr_valid &&
                !out_payload_valid && !rx_done && !exec_start && !tx_start && !tx_done)
    else
    begin
        $error("control outputs not low during reset");
        fail_count++;
    end

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr))
    else
    begin
        $error("reply header dropped or changed before acceptance");
        fail_count++;
    end

    payload_hold: assert property (@(posedge clk) disable iff (rst)
        out_payload_valid && !out_payload_ready |=> out_payload_valid && $stable(out_payload))
    else
    begin
        $error("reply byte dropped or changed under back-pressure");
        fail_count++;
    end

    hdr_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        in_hdr_ready |=> !in_hdr_ready)
    else
    begin
        $error("in_hdr_ready high for more than one cycle");
        fail_count++;
    end

    // receive and reply never overlap
    rx_tx_apart: assert property (@(posedge clk) disable iff (rst)
        !(in_payload_ready && out_payload_valid))
    else
    begin
        $error("in_payload_ready and out_payload_valid high together");
        fail_count++;
    end

endmodule

bind udp_cmd_top udp_cmd_assert udp_cmd_assert_i (.*);

//--- test/udp_cmd_tb.sv
`include "udp_cmd_macros.svh"

module udp_cmd_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] LOCAL_IP   = 32'h0A00_0001;
    localparam logic [31:0] PEER_IP    = 32'h0A00_0002;
    localparam logic [15:0] PEER_PORT  = 16'h4321;

    logic                           clk = 1'b0;
    logic                           rst;
    logic [31:0]                    local_ip;
    udp_cmd_pkg::udp_rx_hdr_t       in_hdr;
    logic                           in_hdr_valid;
    logic                           in_hdr_ready;
    udp_cmd_pkg::axis_byte_t        in_payload;
    logic                           in_payload_valid;
    logic                           in_payload_ready;
    udp_cmd_pkg::udp_tx_hdr_t       out_hdr;
    logic                           out_hdr_valid;
    logic                           out_hdr_ready;
    udp_cmd_pkg::axis_byte_t        out_payload;
    logic                           out_payload_valid;
    logic                           out_payload_ready;
    logic [`NUM_SETTINGS-1:0][15:0] settings;

    integer      seed = 32'h3cd2;
    bit          stall_en;
    logic [15:0] cmd_q[$];
    logic [15:0] dat_q[$];
    logic [15:0] exp_res[$];
    logic [15:0] model_set[`NUM_SETTINGS];
    logic [15:0] good_cnt;
    logic [15:0] bad_cnt;

    always #5 clk = ~clk;

    udp_cmd_top udp_cmd_top_i (.*);

    task automatic stop_with_failure;
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_timeout(input int n, input string what);
        if (n == WAIT_LIMIT)
        begin
            $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
            stop_with_failure();
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic add_cmd(input bit wr, input logic [14:0] addr, input logic [15:0] data);
        cmd_q.push_back({wr, addr});
        dat_q.push_back(data);
    endtask

    task automatic send_header(input logic [15:0] dst_port, input int nbytes);
        int n;
        in_hdr.frag_offset = '0;
        in_hdr.src_ip      = PEER_IP;
        in_hdr.dst_ip      = local_ip;
        in_hdr.src_port    = PEER_PORT;
        in_hdr.dst_port    = dst_port;
        in_hdr.udp_len     = 16'(8 + nbytes);
        in_hdr.err         = 1'b0;
        in_hdr_valid       = 1'b1;
        for (n = 0; n < WAIT_LIMIT; n++)
        begin
            @(negedge clk);
            if (in_hdr_ready)
                break;
            next_cycle();
        end
        check_timeout(n, "in_hdr_ready");
        next_cycle();
        in_hdr_valid = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] data, input logic last);
        int n;
        in_payload.data  = data;
        in_payload.last  = last;
        in_payload_valid = 1'b1;
        for (n = 0; n < WAIT_LIMIT; n++)
        begin
            @(negedge clk);
            if (in_payload_ready)
                break;
            next_cycle();
        end
        check_timeout(n, "in_payload_ready");
        next_cycle();
        in_payload_valid = 1'b0;
    endtask

    // command rules applied to the model register bank
    task automatic predict_results;
        logic [14:0] addr;
        exp_res.delete();
        foreach (cmd_q[k])
        begin
            addr = cmd_q[k][14:0];
            if (cmd_q[k][15])
            begin
                if (addr < `NUM_SETTINGS)
                    model_set[addr] = dat_q[k];
                exp_res.push_back(dat_q[k]);
            end
            else if (addr < `NUM_SETTINGS)
                exp_res.push_back(model_set[addr]);
            else if (addr == `GOOD_CNT_ADDR)
                exp_res.push_back(good_cnt);
            else if (addr == `BAD_CNT_ADDR)
                exp_res.push_back(bad_cnt);
            else
                exp_res.push_back(`BAD_READ_WORD);
        end
    endtask

    task automatic receive_reply(input logic [15:0] seq);
        logic [7:0] exp_bytes[$];
        int         n;
        exp_bytes.push_back(8'h00);
        exp_bytes.push_back(`CMD_PACKET_TYPE);
        exp_bytes.push_back(seq[15:8]);
        exp_bytes.push_back(seq[7:0]);
        foreach (exp_res[k])
        begin
            exp_bytes.push_back(exp_res[k][15:8]);
            exp_bytes.push_back(exp_res[k][7:0]);
        end
        for (n = 0; n < WAIT_LIMIT; n++)
        begin
            out_hdr_ready = stall_en ? 1'($random(seed)) : 1'b1;
            @(negedge clk);
            if (out_hdr_valid && out_hdr_ready)
                break;
            next_cycle();
        end
        check_timeout(n, "the reply header");
        check_value("out_hdr.route.dst_ip", out_hdr.route.dst_ip, PEER_IP);
        check_value("out_hdr.route.src_port", out_hdr.route.src_port, `CTRL_UDP_PORT);
        check_value("out_hdr.route.dst_port", out_hdr.route.dst_port, PEER_PORT);
        check_value("out_hdr.udp_len", out_hdr.udp_len, 12 + 2 * exp_res.size());
        next_cycle();
        out_hdr_ready = 1'b0;
        foreach (exp_bytes[i])
        begin
            for (n = 0; n < WAIT_LIMIT; n++)
            begin
                out_payload_ready = stall_en ? 1'($random(seed)) : 1'b1;
                @(negedge clk);
                if (out_payload_valid && out_payload_ready)
                    break;
                next_cycle();
            end
            check_timeout(n, "a reply byte");
            check_value($sformatf("out_payload.data[%0d]", i), out_payload.data, exp_bytes[i]);
            check_value($sformatf("out_payload.last[%0d]", i), out_payload.last,
                        32'(i == exp_bytes.size() - 1));
            next_cycle();
        end
        out_payload_ready = 1'b0;
    endtask

    task automatic check_settings;
        foreach (model_set[k])
            check_value($sformatf("settings[%0d]", k), settings[k], model_set[k]);
    endtask

    task automatic run_packet(input logic [15:0] seq, input logic [15:0] dst_port,
                              input logic [15:0] final_word, input bit good);
        logic [15:0] words[$];
        int          n;
        words.push_back(seq);
        words.push_back(16'(2 * cmd_q.size() + 1));
        foreach (cmd_q[k])
        begin
            words.push_back(cmd_q[k]);
            words.push_back(dat_q[k]);
        end
        words.push_back(final_word);
        send_header(dst_port, 2 * words.size());
        foreach (words[k])
        begin
            send_byte(words[k][15:8], 1'b0);
            send_byte(words[k][7:0], k == words.size() - 1);
        end
        if (good)
        begin
            predict_results();
            receive_reply(seq);
            good_cnt++;
        end
        else
        begin
            // a dropped packet never raises the reply header
            for (n = 0; n < 20; n++)
            begin
                @(negedge clk);
                check_value("out_hdr_valid", out_hdr_valid, 0);
                next_cycle();
            end
            bad_cnt++;
        end
        check_settings();
        cmd_q.delete();
        dat_q.delete();
    endtask

    always @(negedge clk)
    begin
        if (udp_cmd_top_i.udp_cmd_assert_i.fail_count != 0)
        begin
            $display("a bound handshake assertion failed");
            stop_with_failure();
        end
    end

    initial
    begin
        logic [31:0] r;
        rst               = 1'b1;
        local_ip          = LOCAL_IP;
        in_hdr            = '0;
        in_hdr_valid      = 1'b0;
        in_payload        = '0;
        in_payload_valid  = 1'b0;
        out_hdr_ready     = 1'b0;
        out_payload_ready = 1'b0;
        stall_en          = 1'b0;
        good_cnt          = '0;
        bad_cnt           = '0;
        foreach (model_set[k])
            model_set[k] = '0;
        repeat (16)
            next_cycle();
        check_value("in_hdr_ready", in_hdr_ready, 0);
        check_value("in_payload_ready", in_payload_ready, 0);
        check_value("out_hdr_valid", out_hdr_valid, 0);
        check_value("out_payload_valid", out_payload_valid, 0);
        rst = 1'b0;
        next_cycle();

        add_cmd(1'b0, 15'd0, 16'hFFFF);
        run_packet(16'h0101, `CTRL_UDP_PORT, `MAGIC_WORD, 1'b1);

        add_cmd(1'b1, 15'd2, 16'hA5C3);
        add_cmd(1'b1, 15'd5, 16'h1234);
        add_cmd(1'b0, 15'd2, 16'h0000);
        add_cmd(1'b0, 15'd5, 16'h0000);
        run_packet(16'h0202, `CTRL_UDP_PORT, `MAGIC_WORD, 1'b1);

        // wrong port, then a bad closing word
        add_cmd(1'b1, 15'd3, 16'hDEAD);
        run_packet(16'h0303, 16'h6788, `MAGIC_WORD, 1'b0);
        add_cmd(1'b1, 15'd4, 16'hBEEF);
        run_packet(16'h0304, `CTRL_UDP_PORT, 16'hCBAF, 1'b0);
        add_cmd(1'b0, `BAD_CNT_ADDR, 16'h0000);
        add_cmd(1'b0, `GOOD_CNT_ADDR, 16'h0000);
        run_packet(16'h0305, `CTRL_UDP_PORT, `MAGIC_WORD, 1'b1);

        add_cmd(1'b0, 15'h0123, 16'h0000);
        add_cmd(1'b0, 15'h7FFF, 16'h0000);
        run_packet(16'h0406, `CTRL_UDP_PORT, `MAGIC_WORD, 1'b1);

        // random stalls on both reply handshakes
        stall_en = 1'b1;
        for (int p = 0; p < 4; p++)
        begin
            for (int c = 0; c < 6; c++)
            begin
                r = $random(seed);
                add_cmd(r[0], {11'd0, r[4:1]}, r[31:16]);
            end
            run_packet(16'h0500 + 16'(p), `CTRL_UDP_PORT, `MAGIC_WORD, 1'b1);
        end

        if (udp_cmd_top_i.udp_cmd_assert_i.fail_count == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("a bound handshake assertion failed");
            stop_with_failure();
        end
    end

endmodule

//--- vlog.f
+incdir+hdl
hdl/udp_cmd_pkg.sv
hdl/cmd_seq_ctrl.sv
hdl/udp_cmd_rx.sv
hdl/cmd_exec.sv
hdl/cmd_reg_bank.sv
hdl/udp_reply_tx.sv
hdl/udp_cmd_top.sv
test/udp_cmd_assert.sv
test/udp_cmd_tb.sv
